/* verilog/riscv_ctrl_cfg.svh */
`ifndef RISCV_CTRL_CFG_SVH
`define RISCV_CTRL_CFG_SVH

`define XLEN_INSTR 32

`define OPC_RTYPE  7'b0110011
`define OPC_IMM    7'b0010011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_LUI    7'b0110111
`define OPC_JALR   7'b1100111

`define F3_ADD 3'b000
`define F3_AND 3'b111
`define F3_SLT 3'b010
`define F3_LD  3'b011
`define F3_LB  3'b000
`define F3_LH  3'b001
`define F3_LW  3'b010
`define F3_LBU 3'b100
`define F3_LHU 3'b101
`define F3_LWU 3'b110
`define F3_BEQ 3'b000
`define F3_BNE 3'b001

`define F7_SUB 7'b0100000

`define ASEL_W 2
`define BSEL_W 3

`define ASEL_PC   2'd0
`define ASEL_RS   2'd1
`define ASEL_ZERO 2'd3

`define BSEL_RS    3'd0
`define BSEL_FOUR  3'd1
`define BSEL_IMM   3'd2
`define BSEL_BRIMM 3'd3

`endif

/* verilog/riscv_ctrl_pkg.sv */
package riscv_ctrl_pkg;

    typedef enum logic [3:0] {
        st_reset,
        st_wait,
        st_fetch,
        st_reg_read,
        st_execute,
        st_alu_wb,
        st_one_wb,      // slt result true
        st_zero_wb,     // slt result false
        st_link_wb,
        st_mem_read,
        st_load_wb,
        st_mem_write
    } ctrl_state_e;

    // Instruction class as seen by the decoder
    typedef enum logic [3:0] {
        cls_rtype,
        cls_addi,
        cls_slti,
        cls_load,
        cls_store,
        cls_branch,
        cls_lui,
        cls_jalr,
        cls_unknown
    } instr_class_e;

    typedef enum logic [2:0] {
        alu_nop = 3'd0,
        alu_add = 3'd1,
        alu_sub = 3'd2,
        alu_and = 3'd3,
        alu_slt = 3'd6
    } alu_op_e;

    // Write-back source of the register file mux
    typedef enum logic [3:0] {
        dsel_alu  = 4'd0,
        dsel_one  = 4'd2,
        dsel_zero = 4'd3,
        dsel_pc   = 4'd4,
        dsel_ld   = 4'd5,
        dsel_lb   = 4'd6,
        dsel_lh   = 4'd7,
        dsel_lw   = 4'd8,
        dsel_lbu  = 4'd9,
        dsel_lhu  = 4'd10,
        dsel_lwu  = 4'd11
    } data_sel_e;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne
    } branch_kind_e;

endpackage

/* verilog/decode_if.sv */
`include "riscv_ctrl_cfg.svh"

interface decode_if
    import riscv_ctrl_pkg::*;
();
    alu_op_e              exec_alu_op;
    logic [`ASEL_W-1:0]   exec_a_sel;
    logic [`BSEL_W-1:0]   exec_b_sel;
    logic                 exec_alu_out_write;
    ctrl_state_e          after_exec;       // Successor of st_execute
    logic                 is_slt;
    branch_kind_e         branch_kind;
    data_sel_e            load_sel;

    modport decoder (
        output exec_alu_op, exec_a_sel, exec_b_sel, exec_alu_out_write,
        output after_exec, is_slt, branch_kind, load_sel
    );

    modport fsm (
        input exec_alu_op, exec_a_sel, exec_b_sel, exec_alu_out_write,
        input after_exec, is_slt, branch_kind, load_sel
    );

endinterface

/* verilog/instr_decoder.sv */
`include "riscv_ctrl_cfg.svh"

module instr_decoder
    import riscv_ctrl_pkg::*;
(
    input  logic [`XLEN_INSTR-1:0] instr,
    decode_if.decoder              dec
);

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    instr_class_e cls;
    data_sel_e    load_kind;
    logic         load_ok;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Load width from funct3
    always_comb begin
        load_ok = 1'b1;
        case (funct3)
            `F3_LD:  load_kind = dsel_ld;
            `F3_LB:  load_kind = dsel_lb;
            `F3_LH:  load_kind = dsel_lh;
            `F3_LW:  load_kind = dsel_lw;
            `F3_LBU: load_kind = dsel_lbu;
            `F3_LHU: load_kind = dsel_lhu;
            `F3_LWU: load_kind = dsel_lwu;
            default: begin
                load_kind = dsel_alu;
                load_ok   = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            `OPC_RTYPE: cls = cls_rtype;
            `OPC_IMM: begin
                if (funct3 == `F3_ADD)
                    cls = cls_addi;
                else if (funct3 == `F3_SLT)
                    cls = cls_slti;
                else
                    cls = cls_unknown;
            end
            `OPC_LOAD:  cls = load_ok ? cls_load : cls_unknown;
            `OPC_STORE: cls = cls_store;        // Single store width
            `OPC_BRANCH: begin
                if (funct3 == `F3_BEQ || funct3 == `F3_BNE)
                    cls = cls_branch;
                else
                    cls = cls_unknown;
            end
            `OPC_LUI:   cls = cls_lui;
            `OPC_JALR:  cls = cls_jalr;
            default:    cls = cls_unknown;
        endcase
    end

    always_comb begin
        dec.exec_alu_op        = alu_nop;
        dec.exec_a_sel         = `ASEL_PC;
        dec.exec_b_sel         = `BSEL_RS;
        dec.exec_alu_out_write = 1'b0;
        dec.after_exec         = st_wait;   // Unknown ends after execute
        dec.is_slt             = 1'b0;
        dec.branch_kind        = br_none;
        dec.load_sel           = load_kind;

        case (cls)
            cls_rtype: begin
                dec.exec_a_sel         = `ASEL_RS;
                dec.exec_b_sel         = `BSEL_RS;
                dec.exec_alu_out_write = 1'b1;
                dec.after_exec         = st_alu_wb;
                if (funct7 == `F7_SUB) begin
                    dec.exec_alu_op = alu_sub;
                end else begin
                    case (funct3)
                        `F3_AND: dec.exec_alu_op = alu_and;
                        `F3_SLT: begin
                            dec.exec_alu_op = alu_slt;
                            dec.is_slt      = 1'b1;
                        end
                        default: dec.exec_alu_op = alu_add;
                    endcase
                end
            end
            cls_addi, cls_slti, cls_load, cls_store, cls_jalr, cls_lui: begin
                dec.exec_a_sel         = (cls == cls_lui) ? `ASEL_ZERO : `ASEL_RS;
                dec.exec_b_sel         = `BSEL_IMM;
                dec.exec_alu_out_write = 1'b1;
                dec.exec_alu_op        = (cls == cls_slti) ? alu_slt : alu_add;
                dec.is_slt             = (cls == cls_slti);
                case (cls)
                    cls_load:  dec.after_exec = st_mem_read;
                    cls_store: dec.after_exec = st_mem_write;
                    cls_jalr:  dec.after_exec = st_link_wb;
                    default:   dec.after_exec = st_alu_wb;
                endcase
            end
            cls_branch: begin
                dec.exec_a_sel  = `ASEL_RS;
                dec.exec_b_sel  = `BSEL_RS;
                dec.exec_alu_op = alu_sub;      // Compare through zero flag
                dec.branch_kind = (funct3 == `F3_BEQ) ? br_eq : br_ne;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/ctrl_fsm.sv */
`include "riscv_ctrl_cfg.svh"

module ctrl_fsm
    import riscv_ctrl_pkg::*;
(
    input  logic               CLK,
    input  logic               RST,
    input  logic               zero,
    input  logic               less,
    decode_if.fsm              dec,
    output logic               pc_src_sel,
    output logic               reg_write,
    output logic [3:0]         data_sel,
    output logic               mem_data_reg_write,
    output logic               alu_out_write,
    output logic               mem_write,
    output logic               datapath_reset,
    output logic [2:0]         alu_op,
    output logic               pc_write,
    output logic               ir_load,
    output logic [`ASEL_W-1:0] alu_a_sel,
    output logic [`BSEL_W-1:0] alu_b_sel,
    output logic               reg_a_write,
    output logic               reg_b_write
);

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        br_taken;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST)
            state <= st_reset;
        else
            state <= state_next;
    end

    always_comb begin
        case (state)
            st_reset:    state_next = st_wait;
            st_wait:     state_next = st_fetch;
            st_fetch:    state_next = st_reg_read;
            st_reg_read: state_next = st_execute;
            st_execute: begin
                if (dec.is_slt)
                    state_next = less ? st_one_wb : st_zero_wb;
                else
                    state_next = dec.after_exec;
            end
            st_mem_read: state_next = st_load_wb;
            default:     state_next = st_wait;  // All write-back states end here
        endcase
    end

    assign br_taken = (dec.branch_kind == br_eq && zero) ||
                      (dec.branch_kind == br_ne && !zero);

    always_comb begin
        pc_src_sel         = 1'b1;          // PC+4 path
        reg_write          = 1'b0;
        data_sel           = dsel_alu;
        mem_data_reg_write = 1'b0;
        alu_out_write      = 1'b0;
        mem_write          = 1'b0;
        datapath_reset     = 1'b0;
        alu_op             = alu_nop;
        pc_write           = 1'b0;
        ir_load            = 1'b0;
        alu_a_sel          = `ASEL_PC;
        alu_b_sel          = `BSEL_RS;
        reg_a_write        = 1'b0;
        reg_b_write        = 1'b0;

        case (state)
            st_reset: datapath_reset = 1'b1;
            st_fetch: begin
                ir_load   = 1'b1;
                pc_write  = 1'b1;
                alu_op    = alu_add;
                alu_a_sel = `ASEL_PC;
                alu_b_sel = `BSEL_FOUR;
            end
            st_reg_read: begin
                reg_a_write   = 1'b1;
                reg_b_write   = 1'b1;
                alu_out_write = 1'b1;       // Speculative branch target
                alu_op        = alu_add;
                alu_a_sel     = `ASEL_PC;
                alu_b_sel     = `BSEL_BRIMM;
            end
            st_execute: begin
                alu_op        = dec.exec_alu_op;
                alu_a_sel     = dec.exec_a_sel;
                alu_b_sel     = dec.exec_b_sel;
                alu_out_write = dec.exec_alu_out_write;
                if (br_taken) begin
                    pc_write   = 1'b1;
                    pc_src_sel = 1'b0;      // Target from ALU out
                end
            end
            st_alu_wb: begin
                reg_write = 1'b1;
                data_sel  = dsel_alu;
            end
            st_one_wb: begin
                reg_write = 1'b1;
                data_sel  = dsel_one;
            end
            st_zero_wb: begin
                reg_write = 1'b1;
                data_sel  = dsel_zero;
            end
            st_link_wb: begin
                reg_write  = 1'b1;
                data_sel   = dsel_pc;       // rd gets return address
                pc_write   = 1'b1;
                pc_src_sel = 1'b0;
            end
            st_mem_read: mem_data_reg_write = 1'b1;
            st_load_wb: begin
                reg_write = 1'b1;
                data_sel  = dec.load_sel;
            end
            st_mem_write: mem_write = 1'b1;
            default: ;
        endcase
    end

endmodule

/* verilog/riscv_ctrl.sv */
module riscv_ctrl (
    input  logic        CLK,
    input  logic        RST,
    input  logic [31:0] instr,
    input  logic        zero,
    input  logic        less,
    output logic        pc_src_sel,
    output logic        reg_write,
    output logic [3:0]  data_sel,
    output logic        mem_data_reg_write,
    output logic        alu_out_write,
    output logic        mem_write,
    output logic        datapath_reset,
    output logic [2:0]  alu_op,
    output logic        pc_write,
    output logic        ir_load,
    output logic [1:0]  alu_a_sel,
    output logic [2:0]  alu_b_sel,
    output logic        reg_a_write,
    output logic        reg_b_write
);

    decode_if dec_if ();

    instr_decoder decoder_inst (
        .instr (instr),
        .dec   (dec_if.decoder)
    );

    // Moore outputs except the taken-branch PC update
    ctrl_fsm fsm_inst (
        .CLK                (CLK),
        .RST                (RST),
        .zero               (zero),
        .less               (less),
        .dec                (dec_if.fsm),
        .pc_src_sel         (pc_src_sel),
        .reg_write          (reg_write),
        .data_sel           (data_sel),
        .mem_data_reg_write (mem_data_reg_write),
        .alu_out_write      (alu_out_write),
        .mem_write          (mem_write),
        .datapath_reset     (datapath_reset),
        .alu_op             (alu_op),
        .pc_write           (pc_write),
        .ir_load            (ir_load),
        .alu_a_sel          (alu_a_sel),
        .alu_b_sel          (alu_b_sel),
        .reg_a_write        (reg_a_write),
        .reg_b_write        (reg_b_write)
    );

endmodule

/* verif/clk_gen.sv */
module clk_gen (
    output logic CLK,
    output logic RST
);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    initial begin
        RST = 1'b1;
        repeat (4) @(posedge CLK);
        #1 RST = 1'b0;
    end

endmodule

/* verif/riscv_ctrl_properties.sv */
module riscv_ctrl_properties (
    input logic CLK,
    input logic RST,
    input logic ir_load,
    input logic pc_write,
    input logic reg_write,
    input logic mem_write,
    input logic mem_data_reg_write,
    input logic alu_out_write,
    input logic reg_a_write,
    input logic reg_b_write,
    input logic datapath_reset
);

    fetch_updates_pc: assert property (@(posedge CLK) disable iff (RST) ir_load |-> pc_write)
        else $error("ir_load high without pc_write");

    single_data_write: assert property (@(posedge CLK) disable iff (RST)
        $onehot0({reg_write, mem_write, mem_data_reg_write}))
        else $error("more than one data write strobe high");

    operands_after_fetch: assert property (@(posedge CLK) disable iff (RST)
        ir_load |=> reg_a_write)
        else $error("reg_a_write did not follow ir_load");

    reset_quiet: assert property (@(posedge CLK) datapath_reset |->
        !(ir_load || pc_write || reg_write || mem_write || mem_data_reg_write ||
          alu_out_write || reg_a_write || reg_b_write))
        else $error("strobe high together with datapath_reset");

endmodule

bind riscv_ctrl riscv_ctrl_properties props_inst (.*);

/* verif/riscv_ctrl_tb.sv */
`include "riscv_ctrl_cfg.svh"

module riscv_ctrl_tb
    import riscv_ctrl_pkg::*;
();

    localparam int N_INSTR    = 400;
    localparam int MAX_CYCLES = N_INSTR * 6 + 20;   // Load is the longest class

    // Write-back code of each load by funct3
    localparam data_sel_e LOAD_SEL [7] = '{dsel_lb, dsel_lh, dsel_lw, dsel_ld,
                                           dsel_lbu, dsel_lhu, dsel_lwu};

    logic        CLK, RST, zero, less;
    logic [31:0] instr;
    logic        pc_src_sel, reg_write, mem_data_reg_write, alu_out_write, mem_write;
    logic        datapath_reset, pc_write, ir_load, reg_a_write, reg_b_write;
    logic [3:0]  data_sel;
    logic [2:0]  alu_op, alu_b_sel;
    logic [1:0]  alu_a_sel;

    ctrl_state_e  m_state;          // Model state
    alu_op_e      p_op;             // Expected execute plan of the current instruction
    logic [1:0]   p_a;
    logic [2:0]   p_b;
    logic         p_aow, p_slt;
    ctrl_state_e  p_after;
    branch_kind_e p_br;
    data_sel_e    p_ld;
    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;
    int           n_done = 0;

    clk_gen clk_gen_inst (.CLK(CLK), .RST(RST));

    riscv_ctrl riscv_ctrl_inst (.*);

    task automatic set_plan(logic [6:0] opc, alu_op_e op, logic [1:0] a, logic [2:0] b,
                            logic aow, ctrl_state_e after);
        instr[6:0] = opc;
        p_op       = op;
        p_a        = a;
        p_b        = b;
        p_aow      = aow;
        p_after    = after;
    endtask

    task automatic draw_instr();
        logic [6:0] opc;
        logic [2:0] f3;
        instr = $urandom;
        zero  = 1'($urandom);
        less  = 1'($urandom);
        p_br  = br_none;
        if ($urandom % 10 == 0) begin
            do
                opc = 7'($urandom);
            while (opc inside {`OPC_RTYPE, `OPC_IMM, `OPC_LOAD, `OPC_STORE,
                               `OPC_BRANCH, `OPC_LUI, `OPC_JALR});
            if ($urandom % 2 == 0) begin
                case ($urandom % 3)         // Listed opcode with unlisted funct3
                    0: begin
                        opc = `OPC_LOAD;
                        f3  = 3'b111;
                    end
                    1: begin
                        opc = `OPC_BRANCH;
                        f3  = 3'(2 + $urandom % 6);
                    end
                    default: begin
                        opc = `OPC_IMM;
                        do
                            f3 = 3'($urandom);
                        while (f3 inside {`F3_ADD, `F3_SLT});
                    end
                endcase
                instr[14:12] = f3;
            end
            set_plan(opc, alu_nop, `ASEL_PC, `BSEL_RS, 1'b0, st_wait);
        end else begin
            case ($urandom % 7)
                0: begin
                    instr[31:25] = ($urandom % 4 == 0) ? `F7_SUB : 7'd0;
                    set_plan(`OPC_RTYPE, alu_add, `ASEL_RS, `BSEL_RS, 1'b1, st_alu_wb);
                    if (instr[31:25] == `F7_SUB)
                        p_op = alu_sub;
                    else if (instr[14:12] == `F3_AND)
                        p_op = alu_and;
                    else if (instr[14:12] == `F3_SLT)
                        p_op = alu_slt;
                end
                1: begin
                    instr[14:12] = instr[13] ? `F3_SLT : `F3_ADD;
                    set_plan(`OPC_IMM, alu_add, `ASEL_RS, `BSEL_IMM, 1'b1, st_alu_wb);
                    if (instr[13])
                        p_op = alu_slt;
                end
                2: begin
                    instr[14:12] = 3'($urandom % 7);    // 111 is no load
                    set_plan(`OPC_LOAD, alu_add, `ASEL_RS, `BSEL_IMM, 1'b1, st_mem_read);
                    p_ld = LOAD_SEL[instr[14:12]];
                end
                3: set_plan(`OPC_STORE, alu_add, `ASEL_RS, `BSEL_IMM, 1'b1, st_mem_write);
                4: begin
                    instr[14:12] = instr[12] ? `F3_BNE : `F3_BEQ;
                    set_plan(`OPC_BRANCH, alu_sub, `ASEL_RS, `BSEL_RS, 1'b0, st_wait);
                    p_br = br_eq;
                    if (instr[12])
                        p_br = br_ne;
                end
                5: set_plan(`OPC_LUI, alu_add, `ASEL_ZERO, `BSEL_IMM, 1'b1, st_alu_wb);
                default: set_plan(`OPC_JALR, alu_add, `ASEL_RS, `BSEL_IMM, 1'b1, st_link_wb);
            endcase
        end
        p_slt = (p_op == alu_slt);
    endtask

    function automatic ctrl_state_e model_next(ctrl_state_e s);
        case (s)
            st_reset:    return st_wait;
            st_wait:     return st_fetch;
            st_fetch:    return st_reg_read;
            st_reg_read: return st_execute;
            st_execute:  return p_slt ? (less ? st_one_wb : st_zero_wb) : p_after;
            st_mem_read: return st_load_wb;
            default:     return st_wait;
        endcase
    endfunction

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error: %s expected 0x%0h actual 0x%0h in %s", name, exp, act,
                     m_state.name());
        end
    endtask

    task automatic check_outputs();
        logic       x_src, x_rw, x_mdrw, x_aow, x_mw, x_dpr, x_pcw, x_ir, x_ra, x_rb;
        logic [3:0] x_dsel;
        logic [2:0] x_op, x_b;
        logic [1:0] x_a;
        logic       taken;
        {x_rw, x_mdrw, x_aow, x_mw, x_dpr, x_pcw, x_ir, x_ra, x_rb} = '0;
        {x_dsel, x_op, x_a, x_b} = '0;
        x_src = 1'b1;
        taken = (p_br == br_eq && zero) || (p_br == br_ne && !zero);
        case (m_state)
            st_reset: x_dpr = 1'b1;
            st_fetch: {x_ir, x_pcw, x_op, x_a, x_b} = {2'b11, alu_add, `ASEL_PC, `BSEL_FOUR};
            st_reg_read: {x_ra, x_rb, x_aow, x_op, x_b} = {3'b111, alu_add, `BSEL_BRIMM};
            st_execute: begin
                {x_op, x_a, x_b, x_aow} = {p_op, p_a, p_b, p_aow};
                {x_pcw, x_src} = {taken, !taken};   // Taken branch loads the target
            end
            st_alu_wb:    {x_rw, x_dsel} = {1'b1, dsel_alu};
            st_one_wb:    {x_rw, x_dsel} = {1'b1, dsel_one};
            st_zero_wb:   {x_rw, x_dsel} = {1'b1, dsel_zero};
            st_link_wb:   {x_rw, x_dsel, x_pcw, x_src} = {1'b1, dsel_pc, 2'b10};
            st_mem_read:  x_mdrw = 1'b1;
            st_load_wb:   {x_rw, x_dsel} = {1'b1, p_ld};
            st_mem_write: x_mw = 1'b1;
            default: ;
        endcase
        check_val("pc_src_sel", x_src, pc_src_sel);
        check_val("reg_write", x_rw, reg_write);
        check_val("data_sel", x_dsel, data_sel);
        check_val("mem_data_reg_write", x_mdrw, mem_data_reg_write);
        check_val("alu_out_write", x_aow, alu_out_write);
        check_val("mem_write", x_mw, mem_write);
        check_val("datapath_reset", x_dpr, datapath_reset);
        check_val("alu_op", x_op, alu_op);
        check_val("pc_write", x_pcw, pc_write);
        check_val("ir_load", x_ir, ir_load);
        check_val("alu_a_sel", x_a, alu_a_sel);
        check_val("alu_b_sel", x_b, alu_b_sel);
        check_val("reg_a_write", x_ra, reg_a_write);
        check_val("reg_b_write", x_rb, reg_b_write);
    endtask

    initial begin
        void'($urandom(32'h184));
        {instr, zero, less} = '0;
        m_state = st_reset;
        forever begin
            @(posedge CLK);
            if (RST)
                m_state = st_reset;
            else
                m_state = model_next(m_state);
            if (m_state == st_wait && n_done == N_INSTR)
                break;
            if (m_state == st_wait) begin
                #1;
                draw_instr();
                n_done++;
            end
            @(negedge CLK);                 // Outputs settled mid-cycle
            check_outputs();
        end
        $display("instructions %0d, checks %0d, errors %0d", n_done, checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

/* riscv_ctrl.f */
+incdir+verilog
verilog/riscv_ctrl_pkg.sv
verilog/decode_if.sv
verilog/instr_decoder.sv
verilog/ctrl_fsm.sv
verilog/riscv_ctrl.sv
verif/clk_gen.sv
verif/riscv_ctrl_properties.sv
verif/riscv_ctrl_tb.sv

/* Bender.yml */
package:
  name: riscv_ctrl

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/riscv_ctrl_pkg.sv
      - verilog/decode_if.sv
      - verilog/instr_decoder.sv
      - verilog/ctrl_fsm.sv
      - verilog/riscv_ctrl.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/clk_gen.sv
      - verif/riscv_ctrl_properties.sv
      - verif/riscv_ctrl_tb.sv
